// ==== source/flash_rd_pkg.sv ====
// --------------------
// shared types for the octal-flash read path
// vector typedefs, request / info / beat structs
// receive and transmit state enums
// --------------------

package flash_rd_pkg;

   // returned data width
   localparam int DATA_W = 32;

   // widths with a meaning
   typedef logic [31:0]       flash_addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [7:0]        axi_len_t;
   typedef logic [1:0]        btype_t;
   typedef logic [2:0]        bsize_t;
   typedef logic [3:0]        addr_lsb_t;
   // beats = axi_len + 1, needs one bit more
   typedef logic [8:0]        beat_cnt_t;

   // --------------------
   // host read request
   typedef struct packed {
      flash_addr_t addr;
      axi_len_t    axi_len;
      btype_t      btype;
      bsize_t      bsize;
      logic        cont;
      logic        error;
   } rd_req_t;

   // burst info handed to the read-data side
   typedef struct packed {
      addr_lsb_t addr_lsb;
      axi_len_t  axi_len;
      btype_t    btype;
      bsize_t    bsize;
      logic      err;
   } rd_info_t;

   // beat returned to the host
   typedef struct packed {
      data_t data;
      logic  last;
      logic  err;
   } rd_beat_t;

   // --------------------
   typedef enum logic [1:0] {RCV_IDLE, RD_PROGRS, CONT_RD_PROGRS} rcv_state_e;
   typedef enum logic [1:0] {XMIT_IDLE, CMD, HOLD} xmit_state_e;

endpackage

// ==== source/rcv_cntrl.sv ====
// --------------------
// receive controller
// sequences fresh and continuous reads
// decides end of burst, drives rd_start / rd_done
// --------------------

`timescale 1ns/1ps
module rcv_cntrl
   (
   input  logic                    mem_clk,
   input  logic                    reset_n,
   // host request side
   input  logic                    xfer_valid,
   input  flash_rd_pkg::rd_req_t   req,
   // from transmit engine, pulse
   input  logic                    xmittr_ack,
   // host data handshake, seen for last beat
   input  logic                    rdata_valid,
   input  logic                    rdata_last,
   input  logic                    rdata_ack,
   // abort sources
   input  logic                    dqs_timeout,
   input  logic                    illegal_instrn_err,
   // to transmit engine, ends chip select
   output logic                    rd_done,
   // to acknowledge resolver
   output logic                    cont_rd_ack,
   // to read-data controller
   output logic                    rd_start,
   output flash_rd_pkg::rd_info_t  rd_info
   );

   flash_rd_pkg::rcv_state_e state, next_state;

   logic next_rd_done;
   logic err_xfer, next_err_xfer;
   logic dqs_to_reg, next_dqs_to_reg;
   logic illegal_d1, illegal_reg, next_illegal_reg;
   logic illegal_redge;
   logic in_burst, last_beat, abort, cont_ok;

   // burst info comes straight from the held request
   assign rd_info.addr_lsb = req.addr[3:0];
   assign rd_info.axi_len  = req.axi_len;
   assign rd_info.btype    = req.btype;
   assign rd_info.bsize    = req.bsize;
   assign rd_info.err      = req.error;

   assign illegal_redge = illegal_instrn_err & ~illegal_d1;
   assign in_burst      = (state != flash_rd_pkg::RCV_IDLE);
   assign last_beat     = in_burst & rdata_valid & rdata_last & rdata_ack;

   // timeout or illegal instruction, registered or arriving now
   assign abort = dqs_to_reg | dqs_timeout | illegal_reg | illegal_redge;

   // follow-on request allowed only on a clean burst
   assign cont_ok = xfer_valid & req.cont & ~req.error & ~err_xfer & ~abort;

   assign cont_rd_ack = last_beat & cont_ok;
   assign rd_start    = ((state == flash_rd_pkg::RCV_IDLE) & xfer_valid & xmittr_ack)
                        | cont_rd_ack;

   // --------------------
   // state and event registers
   always_ff @(posedge mem_clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         state       <= flash_rd_pkg::RCV_IDLE;
         rd_done     <= 1'b0;
         err_xfer    <= 1'b0;
         dqs_to_reg  <= 1'b0;
         illegal_d1  <= 1'b0;
         illegal_reg <= 1'b0;
      end
      else
      begin
         state       <= next_state;
         rd_done     <= next_rd_done;
         err_xfer    <= next_err_xfer;
         dqs_to_reg  <= next_dqs_to_reg;
         illegal_d1  <= illegal_instrn_err;
         illegal_reg <= next_illegal_reg;
      end
   end

   // --------------------
   // next state
   always_comb
   begin
      next_state       = state;
      next_rd_done     = 1'b0;
      next_err_xfer    = err_xfer;
      next_dqs_to_reg  = dqs_to_reg;
      next_illegal_reg = illegal_reg;

      case (state)
         flash_rd_pkg::RCV_IDLE:
         begin
            // fresh read, latch the decode error
            if (xfer_valid & xmittr_ack)
            begin
               next_state    = flash_rd_pkg::RD_PROGRS;
               next_err_xfer = req.error;
            end
         end
         flash_rd_pkg::RD_PROGRS, flash_rd_pkg::CONT_RD_PROGRS:
         begin
            // events held until the burst ends
            next_dqs_to_reg  = dqs_to_reg | dqs_timeout;
            next_illegal_reg = illegal_reg | illegal_redge;
            if (last_beat)
            begin
               next_dqs_to_reg  = 1'b0;
               next_illegal_reg = 1'b0;
               if (cont_ok)
               begin
                  // chip select stays low, next burst runs on
                  next_state    = flash_rd_pkg::CONT_RD_PROGRS;
                  next_err_xfer = 1'b0;
               end
               else
               begin
                  next_state   = flash_rd_pkg::RCV_IDLE;
                  next_rd_done = 1'b1;
               end
            end
         end
         default:
         begin
            next_state = flash_rd_pkg::RCV_IDLE;
         end
      endcase
   end

endmodule

// ==== source/xmit_engine.sv ====
// --------------------
// transmit engine
// command phase timing, chip select, command address
// --------------------

`timescale 1ns/1ps
module xmit_engine
   #(
   parameter int CMD_CYCLES = 8
   )
   (
   input  logic                     mem_clk,
   input  logic                     reset_n,
   input  logic                     xfer_valid,
   input  flash_rd_pkg::rd_req_t    req,
   input  logic                     rd_done,
   output logic                     xmittr_ack,
   output logic                     ce,
   output flash_rd_pkg::flash_addr_t cmd_addr
   );

   localparam int CNT_W = $clog2(CMD_CYCLES + 1);
   localparam logic [CNT_W-1:0] CMD_LAST = CNT_W'(CMD_CYCLES);

   flash_rd_pkg::xmit_state_e state;
   logic [CNT_W-1:0]          cmd_cnt;
   flash_rd_pkg::flash_addr_t addr_q;

   // ack lands exactly CMD_CYCLES after the request cycle
   assign xmittr_ack = (state == flash_rd_pkg::CMD) && (cmd_cnt == CMD_LAST);
   assign cmd_addr   = addr_q;

   always_ff @(posedge mem_clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         state   <= flash_rd_pkg::XMIT_IDLE;
         cmd_cnt <= '0;
         ce      <= 1'b1;
      end
      else
      begin
         case (state)
            flash_rd_pkg::XMIT_IDLE:
            begin
               // chip select low one cycle after the request
               if (xfer_valid)
               begin
                  state   <= flash_rd_pkg::CMD;
                  cmd_cnt <= CNT_W'(1);
                  ce      <= 1'b0;
               end
            end
            flash_rd_pkg::CMD:
            begin
               if (xmittr_ack)
                  state <= flash_rd_pkg::HOLD;
               else
                  cmd_cnt <= cmd_cnt + 1'b1;
            end
            flash_rd_pkg::HOLD:
            begin
               // hold through continuous reads
               if (rd_done)
               begin
                  state <= flash_rd_pkg::XMIT_IDLE;
                  ce    <= 1'b1;
               end
            end
            default:
            begin
               state <= flash_rd_pkg::XMIT_IDLE;
               ce    <= 1'b1;
            end
         endcase
      end
   end

   // address captured with the request
   always_ff @(posedge mem_clk)
   begin
      if ((state == flash_rd_pkg::XMIT_IDLE) && xfer_valid)
         addr_q <= req.addr;
   end

endmodule

// ==== source/dqs_watchdog.sv ====
// --------------------
// dqs watchdog
// flags a flash that stopped strobing
// --------------------

`timescale 1ns/1ps
module dqs_watchdog
   #(
   parameter int DQS_LIMIT = 64
   )
   (
   input  logic mem_clk,
   input  logic reset_n,
   input  logic dqs,
   input  logic beat_expected,
   output logic dqs_timeout
   );

   localparam int CNT_W = $clog2(DQS_LIMIT + 1);
   localparam logic [CNT_W-1:0] CNT_LIMIT = CNT_W'(DQS_LIMIT);
   localparam logic [CNT_W-1:0] CNT_LAST  = CNT_W'(DQS_LIMIT - 1);

   logic             dqs_s1, dqs_s2, dqs_s3;
   logic [CNT_W-1:0] idle_cnt;
   logic             level_change;

   assign level_change = dqs_s2 ^ dqs_s3;

   always_ff @(posedge mem_clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         dqs_s1      <= 1'b0;
         dqs_s2      <= 1'b0;
         dqs_s3      <= 1'b0;
         idle_cnt    <= '0;
         dqs_timeout <= 1'b0;
      end
      else
      begin
         // two-flop sync plus edge history
         dqs_s1 <= dqs;
         dqs_s2 <= dqs_s1;
         dqs_s3 <= dqs_s2;
         // saturates at the limit, so only one pulse per stall
         if (!beat_expected || level_change)
            idle_cnt <= '0;
         else if (idle_cnt != CNT_LIMIT)
            idle_cnt <= idle_cnt + 1'b1;
         dqs_timeout <= beat_expected && !level_change && (idle_cnt == CNT_LAST);
      end
   end

endmodule

// ==== source/rdata_ctrl.sv ====
// --------------------
// read-data controller
// beat capture on dqs changes, 4-entry buffer
// last / err flags, host data handshake, timeout fill
// --------------------

`timescale 1ns/1ps
module rdata_ctrl
   (
   input  logic                     mem_clk,
   input  logic                     reset_n,
   input  logic                     rd_start,
   input  flash_rd_pkg::rd_info_t   rd_info,
   input  logic                     dqs,
   input  flash_rd_pkg::data_t      dq,
   input  logic                     dqs_timeout,
   input  logic                     rdata_ack,
   output logic                     rdata_valid,
   output flash_rd_pkg::rd_beat_t   rdata,
   output logic                     beat_expected,
   output logic                     rx_ready
   );

   localparam int DEPTH = 4;

   // sync stages, dq kept in step with dqs
   logic                dqs_s1, dqs_s2, dqs_s3;
   flash_rd_pkg::data_t dq_s1, dq_s2;

   flash_rd_pkg::data_t fifo_data [DEPTH];
   logic [DEPTH-1:0]    fifo_err;
   logic [1:0]          wr_ptr, rd_ptr;
   logic [2:0]          fill;

   flash_rd_pkg::beat_cnt_t cap_left, out_left;
   logic       gen_mode, burst_err, ready_q;
   logic       cap_push, gen_push, push, pop;
   logic [1:0] inflight;
   logic [3:0] occupancy;

   // --------------------
   // capture / fill decisions
   assign cap_push = (dqs_s2 ^ dqs_s3) && (cap_left != '0) && !gen_mode;
   assign gen_push = gen_mode && (cap_left != '0) && (fill != 3'd4);
   assign push     = cap_push | gen_push;
   assign pop      = rdata_valid & rdata_ack;

   // strobes not yet counted, incl. one the flash may have sent last cycle
   assign inflight  = {1'b0, dqs_s1 ^ dqs_s2} + {1'b0, dqs_s2 ^ dqs_s3} + {1'b0, ready_q};
   assign occupancy = {1'b0, fill} + {2'b00, inflight};

   // flash may send one change per cycle seen with rx_ready high
   assign rx_ready      = !gen_mode && (cap_left > {7'd0, inflight}) && (occupancy < 4'd4);
   assign beat_expected = !gen_mode && (cap_left != '0) && (fill != 3'd4);

   // head of buffer to host
   assign rdata_valid = (fill != 3'd0);
   assign rdata.data  = fifo_data[rd_ptr];
   assign rdata.last  = (out_left == 9'd1);
   assign rdata.err   = fifo_err[rd_ptr];

   always_ff @(posedge mem_clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         dqs_s1    <= 1'b0;
         dqs_s2    <= 1'b0;
         dqs_s3    <= 1'b0;
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         fill      <= '0;
         cap_left  <= '0;
         out_left  <= '0;
         gen_mode  <= 1'b0;
         burst_err <= 1'b0;
         ready_q   <= 1'b0;
      end
      else
      begin
         dqs_s1  <= dqs;
         dqs_s2  <= dqs_s1;
         dqs_s3  <= dqs_s2;
         ready_q <= rx_ready;
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         fill <= fill + 3'(push) - 3'(pop);
         // beat counters reload per burst, also on a continuous read
         if (rd_start)
         begin
            cap_left  <= {1'b0, rd_info.axi_len} + 9'd1;
            out_left  <= {1'b0, rd_info.axi_len} + 9'd1;
            burst_err <= rd_info.err;
         end
         else
         begin
            if (push)
               cap_left <= cap_left - 1'b1;
            if (pop)
               out_left <= out_left - 1'b1;
         end
         // stalled flash, make up the rest of the burst
         if (rd_start)
            gen_mode <= 1'b0;
         else if (dqs_timeout)
            gen_mode <= 1'b1;
         else if (cap_left == '0)
            gen_mode <= 1'b0;
      end
   end

   // data path, no reset
   always_ff @(posedge mem_clk)
   begin
      dq_s1 <= dq;
      dq_s2 <= dq_s1;
      if (push)
      begin
         fifo_data[wr_ptr] <= gen_push ? '0 : dq_s2;
         fifo_err[wr_ptr]  <= gen_mode | burst_err;
      end
   end

endmodule

// ==== source/flash_rd_top.sv ====
// --------------------
// octal-flash read path top
// connects transmit, receive, watchdog and read-data blocks
// --------------------

`timescale 1ns/1ps
module flash_rd_top
   #(
   parameter int CMD_CYCLES = 8,
   parameter int DQS_LIMIT  = 64
   )
   (
   input  logic                      mem_clk,
   input  logic                      reset_n,
   // host request
   input  logic                      xfer_valid,
   input  flash_rd_pkg::rd_req_t     req,
   output logic                      xfer_ack,
   // host data
   output logic                      rdata_valid,
   output flash_rd_pkg::rd_beat_t    rdata,
   input  logic                      rdata_ack,
   // flash side
   output logic                      ce,
   output flash_rd_pkg::flash_addr_t cmd_addr,
   input  logic                      dqs,
   input  flash_rd_pkg::data_t       dq,
   output logic                      rx_ready,
   input  logic                      illegal_instrn_err
   );

   logic                   xmittr_ack;
   logic                   cont_rd_ack;
   logic                   rd_start;
   logic                   rd_done;
   logic                   dqs_timeout;
   logic                   beat_expected;
   flash_rd_pkg::rd_info_t rd_info;

   // fresh read acked by the engine, follow-on by the receive side
   assign xfer_ack = xmittr_ack | cont_rd_ack;

   xmit_engine #(
      .CMD_CYCLES (CMD_CYCLES)
   ) u_xmit_engine (
      .mem_clk    (mem_clk),
      .reset_n    (reset_n),
      .xfer_valid (xfer_valid),
      .req        (req),
      .rd_done    (rd_done),
      .xmittr_ack (xmittr_ack),
      .ce         (ce),
      .cmd_addr   (cmd_addr)
   );

   rcv_cntrl u_rcv_cntrl (
      .mem_clk            (mem_clk),
      .reset_n            (reset_n),
      .xfer_valid         (xfer_valid),
      .req                (req),
      .xmittr_ack         (xmittr_ack),
      .rdata_valid        (rdata_valid),
      .rdata_last         (rdata.last),
      .rdata_ack          (rdata_ack),
      .dqs_timeout        (dqs_timeout),
      .illegal_instrn_err (illegal_instrn_err),
      .rd_done            (rd_done),
      .cont_rd_ack        (cont_rd_ack),
      .rd_start           (rd_start),
      .rd_info            (rd_info)
   );

   dqs_watchdog #(
      .DQS_LIMIT (DQS_LIMIT)
   ) u_dqs_watchdog (
      .mem_clk       (mem_clk),
      .reset_n       (reset_n),
      .dqs           (dqs),
      .beat_expected (beat_expected),
      .dqs_timeout   (dqs_timeout)
   );

   rdata_ctrl u_rdata_ctrl (
      .mem_clk       (mem_clk),
      .reset_n       (reset_n),
      .rd_start      (rd_start),
      .rd_info       (rd_info),
      .dqs           (dqs),
      .dq            (dq),
      .dqs_timeout   (dqs_timeout),
      .rdata_ack     (rdata_ack),
      .rdata_valid   (rdata_valid),
      .rdata         (rdata),
      .beat_expected (beat_expected),
      .rx_ready      (rx_ready)
   );

endmodule

// ==== dv/flash_model.sv ====
// --------------------
// behavioural octal flash for the read path
// streams address data on dqs changes
// optional stall at a beat index
// --------------------

`timescale 1ns/1ps
module flash_model
   #(
   parameter int LATENCY = 3
   )
   (
   input  logic                      mem_clk,
   input  logic                      reset_n,
   input  logic                      ce,
   input  flash_rd_pkg::flash_addr_t cmd_addr,
   input  logic                      rx_ready,
   // beat index where strobing stops, negative for none
   input  int                        stall_beat,
   output logic                      dqs,
   output flash_rd_pkg::data_t       dq
   );

   flash_rd_pkg::flash_addr_t addr;
   int                        sent;
   int                        lat;

   always_ff @(posedge mem_clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         dqs  <= 1'b0;
         dq   <= '0;
         addr <= '0;
         sent <= 0;
         lat  <= 0;
      end
      else if (ce)
      begin
         // deselected, next select starts over
         lat  <= 0;
         sent <= 0;
      end
      else if (lat < LATENCY)
      begin
         if (lat == 0)
            addr <= cmd_addr;
         lat <= lat + 1;
      end
      else if (rx_ready && !((stall_beat >= 0) && (sent >= stall_beat)))
      begin
         // one beat per dqs change, runs on across continuous reads
         dqs  <= ~dqs;
         dq   <= addr;
         addr <= addr + 1;
         sent <= sent + 1;
      end
   end

endmodule

// ==== dv/tb_flash_rd_top.sv ====
// --------------------
// testbench for the octal-flash read path
// trace reader, stimulus, beat checker
// watchdog and closing report
// --------------------

`timescale 1ns/1ps
module tb_flash_rd_top;

   localparam int CMD_CYCLES = 8;
   localparam int DQS_LIMIT  = 64;
   localparam int MAX_T      = 32;

   logic mem_clk, reset_n, xfer_valid, xfer_ack, rdata_valid, rdata_ack;
   logic ce, rx_ready, dqs, illegal_instrn_err;
   flash_rd_pkg::rd_req_t     req;
   flash_rd_pkg::rd_beat_t    rdata;
   flash_rd_pkg::flash_addr_t cmd_addr;
   flash_rd_pkg::data_t       dq;
   int                        stall_beat;

   // trace columns
   logic [31:0] t_addr [MAX_T];
   int t_len [MAX_T], t_btype [MAX_T], t_bsize [MAX_T], t_cont [MAX_T], t_err [MAX_T];
   int t_chain [MAX_T], t_stall [MAX_T], t_ill [MAX_T], t_bp [MAX_T], t_exp [MAX_T];

   // values driven on the next rising edge
   flash_rd_pkg::rd_req_t nxt_req;
   logic        nxt_valid, nxt_ill, bp_en;
   int          nxt_stall;
   logic [31:0] lfsr;
   int          n_trans, n_checks, n_errors, limit_cycles;
   bit          limit_ready;

   flash_rd_top #(.CMD_CYCLES(CMD_CYCLES), .DQS_LIMIT(DQS_LIMIT)) dut (
      .mem_clk(mem_clk), .reset_n(reset_n), .xfer_valid(xfer_valid), .req(req),
      .xfer_ack(xfer_ack), .rdata_valid(rdata_valid), .rdata(rdata),
      .rdata_ack(rdata_ack), .ce(ce), .cmd_addr(cmd_addr), .dqs(dqs), .dq(dq),
      .rx_ready(rx_ready), .illegal_instrn_err(illegal_instrn_err)
   );

   flash_model u_flash (
      .mem_clk(mem_clk), .reset_n(reset_n), .ce(ce), .cmd_addr(cmd_addr),
      .rx_ready(rx_ready), .stall_beat(stall_beat), .dqs(dqs), .dq(dq)
   );

   initial
   begin
      mem_clk = 1'b0;
      forever #50 mem_clk = ~mem_clk;
   end

   // fibonacci lfsr, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
      n_checks++;
      if (exp !== act)
      begin
         n_errors++;
         $display("ERROR t=%0t %s expected %0h actual %0h", $time, name, exp, act);
      end
   endtask

   // drive on the rising edge, sample on the falling edge
   task automatic next_cycle;
      @(posedge mem_clk);
      if (bp_en)
         lfsr = lfsr_step(lfsr);
      xfer_valid         <= nxt_valid;
      req                <= nxt_req;
      illegal_instrn_err <= nxt_ill;
      stall_beat         <= nxt_stall;
      rdata_ack          <= bp_en ? lfsr[0] : 1'b1;
      @(negedge mem_clk);
   endtask

   function automatic flash_rd_pkg::rd_req_t req_of(input int k);
      flash_rd_pkg::rd_req_t r;
      r.addr    = t_addr[k];
      r.axi_len = 8'(t_len[k]);
      r.btype   = 2'(t_btype[k]);
      r.bsize   = 3'(t_bsize[k]);
      r.cont    = t_cont[k][0];
      r.error   = t_err[k][0];
      return r;
   endfunction

   // host moves on to a chained follow-on or drops valid
   task automatic present_next(input int k);
      if ((k + 1 < n_trans) && (t_chain[k+1] != 0))
      begin
         nxt_req   = req_of(k + 1);
         nxt_valid = 1'b1;
      end
      else
         nxt_valid = 1'b0;
   endtask

   // command phase counted from the cycle the engine sees the request
   task automatic wait_ack(input int k);
      int cyc;
      bit started;
      cyc     = 0;
      started = 0;
      while (1)
      begin
         if (!started && ce)
         begin
            started = 1;
            cyc     = 0;
         end
         if (xfer_ack)
         begin
            if (!started)
            begin
               n_errors++;
               $display("transfer %0d acknowledged before its command phase", k);
            end
            compare("xfer_ack latency", 64'(CMD_CYCLES), 64'(cyc));
            compare("cmd_addr", 64'(t_addr[k]), 64'(cmd_addr));
            break;
         end
         next_cycle();
         if (started)
            cyc++;
      end
      present_next(k);
   endtask

   task automatic read_beats(input int k, input bit hold_ce, output bit acked_next);
      int          i;
      bit          stalled;
      logic [31:0] exp_data;
      int          exp_ack;
      i = 0;
      while (i <= t_len[k])
      begin
         next_cycle();
         if (hold_ce)
            compare("ce", 64'd0, 64'(ce));
         if (rdata_valid && rdata_ack)
         begin
            stalled  = (t_stall[k] >= 0) && (i >= t_stall[k]);
            exp_data = stalled ? 32'd0 : t_addr[k] + 32'(i);
            compare("rdata.data", 64'(exp_data), 64'(rdata.data));
            compare("rdata.last", 64'(i == t_len[k]), 64'(rdata.last));
            compare("rdata.err", stalled ? 64'd1 : 64'(t_err[k]), 64'(rdata.err));
            // illegal instruction edge just after the first beat
            if ((i == 0) && (t_ill[k] != 0))
               nxt_ill = 1'b1;
            i++;
            if (rdata.last)
               break;
         end
      end
      exp_ack = ((k + 1 < n_trans) && (t_chain[k+1] != 0)) ? t_exp[k+1] : 0;
      compare("xfer_ack at last beat", 64'(exp_ack), 64'(xfer_ack));
      nxt_ill    = 1'b0;
      acked_next = xfer_ack;
   endtask

   // watchdog sized from the trace
   initial
   begin
      wait (limit_ready);
      repeat (limit_cycles) @(posedge mem_clk);
      $display("run did not finish within %0d cycles, DUT stopped responding", limit_cycles);
      $display("TESTBENCH FAILED");
      $finish;
   end

   initial
   begin
      int    fd, k, err_before, a_len, a_bt, a_bs, a_c, a_e, a_ch, a_st, a_il, a_bp, a_ex;
      bit    acked, acked_next;
      string line;
      logic [31:0] a_addr;
      xfer_valid = 1'b0;
      req = '0;
      rdata_ack = 1'b0;
      illegal_instrn_err = 1'b0;
      stall_beat = -1;
      reset_n = 1'b0;
      nxt_req = '0;
      nxt_valid = 1'b0;
      nxt_ill = 1'b0;
      nxt_stall = -1;
      bp_en = 1'b0;
      lfsr = 32'h6ab10437;
      n_trans = 0;
      n_checks = 0;
      n_errors = 0;
      limit_cycles = 20;

      fd = $fopen("dv/flash_rd_trace.txt", "r");
      if (fd == 0)
      begin
         $display("cannot open the trace file dv/flash_rd_trace.txt");
         n_errors++;
      end
      else
      begin
         while ($fgets(line, fd) != 0)
         begin
            if ((line.len() < 2) || (line.getc(0) == "#"))
               continue;
            if ($sscanf(line, "%h %h %h %h %h %h %h %d %h %h %h", a_addr, a_len, a_bt,
                        a_bs, a_c, a_e, a_ch, a_st, a_il, a_bp, a_ex) != 11)
               continue;
            t_addr[n_trans] = a_addr;
            t_len[n_trans] = a_len;
            t_btype[n_trans] = a_bt;
            t_bsize[n_trans] = a_bs;
            t_cont[n_trans] = a_c;
            t_err[n_trans] = a_e;
            t_chain[n_trans] = a_ch;
            t_stall[n_trans] = a_st;
            t_ill[n_trans] = a_il;
            t_bp[n_trans] = a_bp;
            t_exp[n_trans] = a_ex;
            limit_cycles += CMD_CYCLES + (a_len + 1) * 8 + DQS_LIMIT + 50;
            n_trans++;
         end
         $fclose(fd);
      end
      limit_ready = 1;

      repeat (10) @(posedge mem_clk);
      reset_n <= 1'b1;
      @(negedge mem_clk);
      compare("ce after reset", 64'd1, 64'(ce));
      compare("xfer_ack after reset", 64'd0, 64'(xfer_ack));
      compare("rdata_valid after reset", 64'd0, 64'(rdata_valid));
      compare("rx_ready after reset", 64'd0, 64'(rx_ready));

      acked = 0;
      for (k = 0; k < n_trans; k++)
      begin
         err_before = n_errors;
         bp_en = (t_bp[k] != 0);
         if (t_chain[k] == 0)
         begin
            nxt_req   = req_of(k);
            nxt_valid = 1'b1;
            nxt_stall = t_stall[k];
            next_cycle();
         end
         if (!acked)
            wait_ack(k);
         read_beats(k, acked, acked_next);
         if (acked_next)
            present_next(k + 1);
         else
         begin
            // rd_done then chip select release
            next_cycle();
            compare("ce before release", 64'd0, 64'(ce));
            next_cycle();
            compare("ce release", 64'd1, 64'(ce));
            // no beats wanted once the burst is over
            compare("rx_ready after burst", 64'd0, 64'(rx_ready));
         end
         acked = acked_next;
         $display("transfer %0d addr %h beats %0d %s", k, t_addr[k], t_len[k] + 1,
                  (n_errors == err_before) ? "ok" : "mismatch");
      end

      $display("transfers %0d checks %0d errors %0d", n_trans, n_checks, n_errors);
      if (n_errors == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// ==== dv/flash_rd_trace.txt ====
# addr len btype bsize cont error chain stall ill bp exp_cont_ack  (hex except stall, decimal)
# chain: presented during the previous burst; stall -1 for none; bp: random back-pressure
00001000 03 1 2 0 0 0 -1 0 0 0
00002000 07 1 2 0 0 0 -1 0 1 0
00003000 00 1 2 0 0 0 -1 0 0 0
00004000 03 1 2 0 1 0 -1 0 1 0
00005000 03 1 2 0 0 0 -1 0 0 0
00005004 03 1 2 1 0 1 -1 0 1 1
00005008 01 1 2 1 0 1 -1 0 1 1
00006000 03 1 2 0 0 0 -1 0 0 0
00006004 03 1 2 1 1 1 -1 0 1 0
00007000 05 1 2 0 0 0 -1 1 0 0
00007006 02 1 2 1 0 1 -1 0 0 0
00008000 07 1 2 0 0 0 3 0 1 0
00009000 03 1 2 0 0 0 -1 0 0 0
00009004 03 1 2 1 0 1 -1 1 1 1
00009008 01 1 2 1 0 1 -1 0 0 0
0000a000 02 1 2 0 0 0 -1 0 1 0
0000a003 02 1 2 0 0 1 -1 0 0 0
0000b000 0f 1 2 0 0 0 5 0 0 0
0000c000 05 1 2 0 0 0 -1 0 1 0

// ==== flash_rd_top.f ====
source/flash_rd_pkg.sv
source/rcv_cntrl.sv
source/xmit_engine.sv
source/dqs_watchdog.sv
source/rdata_ctrl.sv
source/flash_rd_top.sv
dv/flash_model.sv
dv/tb_flash_rd_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TB_TOP    ?= tb_flash_rd_top
RTL_TOP   ?= flash_rd_top
FILELIST  ?= flash_rd_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
RTL_SRCS  ?= source/flash_rd_pkg.sv source/rcv_cntrl.sv source/xmit_engine.sv \
             source/dqs_watchdog.sv source/rdata_ctrl.sv source/flash_rd_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
